//--- design/mrs_pkg.sv
// Shared definitions for the memory read stage
// Field widths of a transaction
// Walk flag enum and the transaction struct
// State encodings of the grant and retire state machines

`default_nettype none

package mrs_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned MRS_ID_W   = 4;
    localparam int unsigned MRS_ADDR_W = 32;
    localparam int unsigned MRS_DATA_W = 32;

    // Whether a transaction needs a memory read
    typedef enum logic {
        MRS_WALK_SKIP = 1'b0,
        MRS_WALK_DO   = 1'b1
    } mrs_walk_e;

    // One transaction as it moves through the stage
    typedef struct packed {
        logic [MRS_ID_W-1:0]   id;
        mrs_walk_e             walk;
        logic [MRS_ADDR_W-1:0] addr;
        // Filled from the memory word on walking transactions
        logic [MRS_DATA_W-1:0] result;
    } mrs_txn_t;

    ////////////////////////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        GNT_IDLE,
        GNT_WAIT_GRANT,
        GNT_WAIT_ROOM
    } mrs_grant_state_e;

    typedef enum logic {
        RET_PASS,
        RET_BUFFER
    } mrs_retire_state_e;

endpackage

`default_nettype wire

//--- design/mrs_fifo.sv
// Synchronous FIFO of transactions
// Circular buffer with read and write pointers and a fill count
// Head entry is read from registered storage, no fall-through
// Overflow and underflow checks

`timescale 1ns/1ns
`default_nettype none

module mrs_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  mrs_pkg::mrs_txn_t            data_i,
    input  logic                         pop_i,
    output mrs_pkg::mrs_txn_t            data_o,
    output logic                         full_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   usage_o
);

    import mrs_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mrs_txn_t         mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (cnt_q == CNT_W'(DEPTH));
    assign empty_o = (cnt_q == '0);
    assign usage_o = cnt_q;
    // Head is visible the cycle after its push
    assign data_o  = mem_q[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
            end
            if (do_push && !do_pop) begin
                cnt_q <= cnt_q + CNT_W'(1);
            end else if (do_pop && !do_push) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // The room rule upstream must keep every queue from overflowing
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o))
        else $error("push into a full FIFO");
    assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_o))
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

//--- design/mrs_issue.sv
// Issue side of the memory read stage
// Input register for one transaction
// Grant state machine that requests memory reads
// Room rule over the grant queue and the output buffer

`timescale 1ns/1ns
`default_nettype none

module mrs_issue #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Previous stage
    input  logic                            in_valid_i,
    input  mrs_pkg::mrs_txn_t               in_data_i,
    output logic                            in_ready_o,
    // Memory request side
    output logic                            mem_req_o,
    output logic [mrs_pkg::MRS_ADDR_W-1:0]  mem_addr_o,
    input  logic                            mem_gnt_i,
    // Queue fill levels
    input  logic [$clog2(DEPTH+1)-1:0]      grant_usage_i,
    input  logic [$clog2(DEPTH+1)-1:0]      out_usage_i,
    // Grant queue write side
    output logic                            push_o,
    output mrs_pkg::mrs_txn_t               push_data_o
);

    import mrs_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W:0] DEPTH_C = (CNT_W + 1)'(DEPTH);

    mrs_grant_state_e state_q, state_d;
    mrs_txn_t         reg_data_q;
    logic             reg_valid_q, reg_valid_d;
    logic             ready_q, ready_d;
    logic             accept;
    logic             reg_walk;
    logic [CNT_W:0]   stage_usage;
    logic             room;
    logic             room_after_push;

    ////////////////////////////////////////////////////////////
    // Room rule
    ////////////////////////////////////////////////////////////

    // Entries held in the grant queue and the output buffer together
    assign stage_usage     = {1'b0, grant_usage_i} + {1'b0, out_usage_i};
    assign room            = stage_usage < DEPTH_C;
    // Counting the push of this cycle
    assign room_after_push = (stage_usage + (CNT_W + 1)'(1)) < DEPTH_C;

    assign accept      = in_valid_i && ready_q;
    assign reg_walk    = (reg_data_q.walk == MRS_WALK_DO);
    assign in_ready_o  = ready_q;
    assign mem_addr_o  = reg_data_q.addr;
    assign push_data_o = reg_data_q;

    ////////////////////////////////////////////////////////////
    // Grant state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d   = state_q;
        mem_req_o = 1'b0;
        push_o    = 1'b0;
        case (state_q)
            GNT_IDLE: begin
                if (reg_valid_q && room) begin
                    if (reg_walk) begin
                        mem_req_o = 1'b1;
                        // Grant may already be high before the request
                        if (mem_gnt_i) begin
                            push_o = 1'b1;
                        end else begin
                            state_d = GNT_WAIT_GRANT;
                        end
                    end else begin
                        // Skip transactions go to the queue at once
                        push_o = 1'b1;
                    end
                end
            end
            GNT_WAIT_GRANT: begin
                mem_req_o = 1'b1;
                push_o    = mem_gnt_i;
            end
            GNT_WAIT_ROOM: begin
                // No request here, only wait for the queues to drain
                if (room) begin
                    state_d = GNT_IDLE;
                end
            end
            default: begin
                state_d = GNT_IDLE;
            end
        endcase
        // After a push stay closed while the stage is full
        if (push_o) begin
            state_d = room_after_push ? GNT_IDLE : GNT_WAIT_ROOM;
        end
    end

    // Register frees on push and fills on accept, never both
    always_comb begin
        reg_valid_d = reg_valid_q;
        if (accept) begin
            reg_valid_d = 1'b1;
        end else if (push_o) begin
            reg_valid_d = 1'b0;
        end
        ready_d = !reg_valid_d && (state_d == GNT_IDLE);
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q     <= GNT_IDLE;
            reg_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            state_q     <= state_d;
            reg_valid_q <= reg_valid_d;
            ready_q     <= ready_d;
        end
    end

    // Input payload
    always_ff @(posedge clk_i) begin
        if (accept) begin
            reg_data_q <= in_data_i;
        end
    end

    // A pending request keeps its address until the memory grants it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
        else $error("request address changed before grant");

endmodule

`default_nettype wire

//--- design/mrs_retire.sv
// Retire side of the memory read stage
// Pairs grant queue heads with queued memory responses
// Passthrough and buffer state machine toward the next stage

`timescale 1ns/1ns
`default_nettype none

module mrs_retire #(
    parameter int unsigned DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    // Grant queue read side
    input  mrs_pkg::mrs_txn_t grant_data_i,
    input  logic              grant_empty_i,
    output logic              grant_pop_o,
    // Response queue read side
    input  mrs_pkg::mrs_txn_t resp_data_i,
    input  logic              resp_empty_i,
    output logic              resp_pop_o,
    // Output buffer
    input  mrs_pkg::mrs_txn_t buf_data_i,
    input  logic              buf_empty_i,
    input  logic              buf_full_i,
    output logic              buf_push_o,
    output mrs_pkg::mrs_txn_t buf_push_data_o,
    output logic              buf_pop_o,
    // Next stage
    output logic              out_valid_o,
    output mrs_pkg::mrs_txn_t out_data_o,
    input  logic              out_ready_i
);

    import mrs_pkg::*;

    mrs_retire_state_e state_q, state_d;
    mrs_txn_t          retired;
    logic              head_walk;
    logic              head_ok;
    logic              take;

    ////////////////////////////////////////////////////////////
    // Head pairing
    ////////////////////////////////////////////////////////////

    assign head_walk = (grant_data_i.walk == MRS_WALK_DO);
    // Responses come in grant order so the response head belongs to this head
    assign head_ok   = !grant_empty_i && (!head_walk || !resp_empty_i);

    always_comb begin
        retired = grant_data_i;
        if (head_walk) begin
            retired.result = resp_data_i.result;
        end
    end

    assign grant_pop_o     = take;
    assign resp_pop_o      = take && head_walk;
    assign buf_push_data_o = retired;

    ////////////////////////////////////////////////////////////
    // Output state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d     = state_q;
        take        = 1'b0;
        buf_push_o  = 1'b0;
        buf_pop_o   = 1'b0;
        out_valid_o = 1'b0;
        out_data_o  = retired;
        case (state_q)
            RET_PASS: begin
                // Buffer is empty here so the head goes straight out
                out_valid_o = head_ok;
                if (head_ok && out_ready_i) begin
                    take = 1'b1;
                end else if (head_ok && !buf_full_i) begin
                    take       = 1'b1;
                    buf_push_o = 1'b1;
                    state_d    = RET_BUFFER;
                end
            end
            RET_BUFFER: begin
                if (buf_empty_i) begin
                    state_d = RET_PASS;
                end else begin
                    // Oldest results leave from the buffer head
                    out_valid_o = 1'b1;
                    out_data_o  = buf_data_i;
                    buf_pop_o   = out_ready_i;
                    // Newer heads queue up behind them
                    if (head_ok && !buf_full_i) begin
                        take       = 1'b1;
                        buf_push_o = 1'b1;
                    end
                end
            end
            default: begin
                state_d = RET_PASS;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= RET_PASS;
        end else begin
            state_q <= state_d;
        end
    end

    // An offered result stays on the port until the next stage takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("offered result dropped or changed");

endmodule

`default_nettype wire

//--- design/mem_read_stage.sv
// Top level of the memory read stage
// Issue block and retire block
// Grant queue, response queue and output buffer

`timescale 1ns/1ns
`default_nettype none

module mem_read_stage #(
    parameter int unsigned DEPTH = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    // Previous stage
    input  logic                            in_valid_i,
    input  mrs_pkg::mrs_txn_t               in_data_i,
    output logic                            in_ready_o,
    // Next stage
    output logic                            out_valid_o,
    output mrs_pkg::mrs_txn_t               out_data_o,
    input  logic                            out_ready_i,
    // Memory read port
    output logic                            mem_req_o,
    output logic [mrs_pkg::MRS_ADDR_W-1:0]  mem_addr_o,
    input  logic                            mem_gnt_i,
    input  logic                            mem_rvalid_i,
    input  logic [mrs_pkg::MRS_DATA_W-1:0]  mem_rdata_i
);

    import mrs_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);

    // Grant queue
    logic             grant_push, grant_pop, grant_empty;
    mrs_txn_t         grant_push_data, grant_data;
    logic [CNT_W-1:0] grant_usage;
    // Response queue
    logic             resp_pop, resp_empty;
    mrs_txn_t         resp_push_data, resp_data;
    // Output buffer
    logic             buf_push, buf_pop, buf_empty, buf_full;
    mrs_txn_t         buf_push_data, buf_data;
    logic [CNT_W-1:0] buf_usage;

    // Only the result field travels through the response queue
    assign resp_push_data = '{id: '0, walk: MRS_WALK_SKIP, addr: '0, result: mem_rdata_i};

    mrs_issue #(.DEPTH(DEPTH)) issue_u (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_ready_o(in_ready_o),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_gnt_i(mem_gnt_i),
        .grant_usage_i(grant_usage), .out_usage_i(buf_usage),
        .push_o(grant_push), .push_data_o(grant_push_data)
    );

    mrs_fifo #(.DEPTH(DEPTH)) grant_q (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(grant_push), .data_i(grant_push_data),
        .pop_i(grant_pop), .data_o(grant_data),
        .full_o(), .empty_o(grant_empty), .usage_o(grant_usage)
    );

    // Each read answer is captured the cycle it arrives
    mrs_fifo #(.DEPTH(DEPTH)) resp_q (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(mem_rvalid_i), .data_i(resp_push_data),
        .pop_i(resp_pop), .data_o(resp_data),
        .full_o(), .empty_o(resp_empty), .usage_o()
    );

    mrs_fifo #(.DEPTH(DEPTH)) out_q (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .push_i(buf_push), .data_i(buf_push_data),
        .pop_i(buf_pop), .data_o(buf_data),
        .full_o(buf_full), .empty_o(buf_empty), .usage_o(buf_usage)
    );

    mrs_retire #(.DEPTH(DEPTH)) retire_u (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .grant_data_i(grant_data), .grant_empty_i(grant_empty), .grant_pop_o(grant_pop),
        .resp_data_i(resp_data), .resp_empty_i(resp_empty), .resp_pop_o(resp_pop),
        .buf_data_i(buf_data), .buf_empty_i(buf_empty), .buf_full_i(buf_full),
        .buf_push_o(buf_push), .buf_push_data_o(buf_push_data), .buf_pop_o(buf_pop),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i)
    );

endmodule

`default_nettype wire

//--- bench/mrs_checker.sv
// Checker for the memory read stage
// Reference model of the expected output transaction
// In-order compare of every output transfer
// Count of memory reads granted and not yet answered

`timescale 1ns/1ns
`default_nettype none

module mrs_checker #(
    parameter int unsigned DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic [8*24-1:0]   test_name_i,
    // Input port of the DUT
    input  logic              in_valid_i,
    input  mrs_pkg::mrs_txn_t in_data_i,
    input  logic              in_ready_i,
    // Output port of the DUT
    input  logic              out_valid_i,
    input  mrs_pkg::mrs_txn_t out_data_i,
    input  logic              out_ready_i,
    // Memory port
    input  logic              mem_req_i,
    input  logic              mem_gnt_i,
    input  logic              mem_rvalid_i,
    // Running counts for the test sequence
    output int                in_count_o,
    output int                out_count_o,
    output int                err_count_o,
    output int                req_cycles_o,
    output int                outstanding_o
);

    import mrs_pkg::*;

    localparam logic [31:0] RESP_KEY = 32'h5a5a_a5a5;

    // Expected outputs in input order
    mrs_txn_t expect_q[$];

    // Walking transactions carry the memory word, skips keep their own result
    function automatic mrs_txn_t reference_result(input mrs_txn_t txn);
        mrs_txn_t res;
        res = txn;
        if (txn.walk == MRS_WALK_DO) begin
            res.result = txn.addr ^ RESP_KEY;
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Sampling on the rising edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : compare_blk
        mrs_txn_t exp_txn;
        int       next_out;
        if (!rst_ni) begin
            expect_q.delete();
            in_count_o    = 0;
            out_count_o   = 0;
            err_count_o   = 0;
            req_cycles_o  = 0;
            outstanding_o = 0;
        end else begin
            if (in_valid_i && in_ready_i) begin
                expect_q.push_back(reference_result(in_data_i));
                in_count_o++;
            end
            if (out_valid_i && out_ready_i) begin
                out_count_o++;
                if (expect_q.size() == 0) begin
                    $display("Output transfer with no pending input in test %0s",
                             test_name_i);
                    err_count_o++;
                end else begin
                    exp_txn = expect_q.pop_front();
                    if (out_data_i !== exp_txn) begin
                        $display("Fail %0s: expected %h actual %h",
                                 test_name_i, exp_txn, out_data_i);
                        err_count_o++;
                    end
                end
            end
            if (mem_req_i) begin
                req_cycles_o++;
            end
            // Granted reads minus answers
            next_out = outstanding_o;
            if (mem_req_i && mem_gnt_i) begin
                next_out++;
            end
            if (mem_rvalid_i) begin
                next_out--;
            end
            if (next_out > int'(DEPTH)) begin
                $display("More than %0d reads outstanding in test %0s", DEPTH, test_name_i);
                err_count_o++;
            end
            outstanding_o = next_out;
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_read_stage.sv
// Testbench for the memory read stage
// Clock, reset and a memory model with random grant and answer delays
// Random stimulus, test sequence and closing summary

`timescale 1ns/1ns
`default_nettype none

module tb_mem_read_stage;

    import mrs_pkg::*;

    localparam int unsigned DEPTH       = 4;
    localparam logic [31:0] RESP_KEY    = 32'h5a5a_a5a5;
    localparam int          SEND_LIMIT  = 500;
    localparam int          DRAIN_LIMIT = 5000;
    localparam int          FILL_CYCLES = 40;

    logic                  clk_i;
    logic                  rst_ni;
    logic                  in_valid_i;
    mrs_txn_t              in_data_i;
    logic                  in_ready_o;
    logic                  out_valid_o;
    mrs_txn_t              out_data_o;
    logic                  out_ready_i;
    logic                  mem_req_o;
    logic [MRS_ADDR_W-1:0] mem_addr_o;
    logic                  mem_gnt_i;
    logic                  mem_rvalid_i;
    logic [MRS_DATA_W-1:0] mem_rdata_i;

    logic [8*24-1:0]       test_name;
    int                    in_count;
    int                    out_count;
    int                    err_count;
    int                    req_cycles;
    int                    outstanding;
    integer                seed = 32'hfba8;
    // Percent chances per cycle
    int                    gnt_pct;
    int                    rsp_pct;
    int                    rdy_pct;
    int                    tb_errors;
    int                    test_count;
    int                    txn_total;
    logic [MRS_ID_W-1:0]   next_id;
    // Granted addresses waiting for their answer
    logic [MRS_ADDR_W-1:0] pend_q[$];

    mem_read_stage #(.DEPTH(DEPTH)) i_mem_read_stage (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_ready_o(in_ready_o),
        .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i),
        .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .mem_gnt_i(mem_gnt_i),
        .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i)
    );

    mrs_checker #(.DEPTH(DEPTH)) i_checker (
        .clk_i(clk_i), .rst_ni(rst_ni), .test_name_i(test_name),
        .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_ready_i(in_ready_o),
        .out_valid_i(out_valid_o), .out_data_i(out_data_o), .out_ready_i(out_ready_i),
        .mem_req_i(mem_req_o), .mem_gnt_i(mem_gnt_i), .mem_rvalid_i(mem_rvalid_i),
        .in_count_o(in_count), .out_count_o(out_count), .err_count_o(err_count),
        .req_cycles_o(req_cycles), .outstanding_o(outstanding)
    );

    always #5 clk_i = ~clk_i;

    function automatic logic chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return (r % 100) < pct;
    endfunction

    function automatic mrs_txn_t make_txn(input int pct);
        mrs_txn_t txn;
        txn.id     = next_id;
        next_id    = next_id + 1'b1;
        txn.walk   = chance(pct) ? MRS_WALK_DO : MRS_WALK_SKIP;
        txn.addr   = $random(seed);
        txn.result = $random(seed);
        return txn;
    endfunction

    ////////////////////////////////////////////////////////////
    // Memory model and next stage readiness
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            pend_q.delete();
        end else if (mem_req_o && mem_gnt_i) begin
            pend_q.push_back(mem_addr_o);
        end
        #1;
        // Grant may be high with no request pending
        mem_gnt_i    = chance(gnt_pct);
        mem_rvalid_i = 1'b0;
        if (rst_ni && pend_q.size() > 0 && chance(rsp_pct)) begin
            mem_rvalid_i = 1'b1;
            mem_rdata_i  = pend_q.pop_front() ^ RESP_KEY;
        end
        out_ready_i = chance(rdy_pct);
    end

    ////////////////////////////////////////////////////////////
    // Tasks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s in test %0s", msg, test_name);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    // Holds valid until the handshake, then drops it
    task automatic finish_send();
        int waited;
        waited = 0;
        @(posedge clk_i);
        while (!in_ready_o) begin
            waited++;
            if (waited > SEND_LIMIT) begin
                abort_run("Input handshake never completed");
            end
            @(posedge clk_i);
        end
        #1;
        in_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (out_count != in_count) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                abort_run("Outputs stopped before all inputs came out");
            end
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic report_test(input int count, input int errs_before);
        test_count++;
        txn_total += count;
        $display("Test %0s: %0d transactions, %0d errors",
                 test_name, count, err_count + tb_errors - errs_before);
    endtask

    task automatic run_random_test(input logic [8*24-1:0] name, input int count,
                                   input int walk, input int gnt, input int rsp,
                                   input int rdy);
        int errs_before;
        int reqs_before;
        test_name   = name;
        gnt_pct     = gnt;
        rsp_pct     = rsp;
        rdy_pct     = rdy;
        errs_before = err_count + tb_errors;
        reqs_before = req_cycles;
        for (int i = 0; i < count; i++) begin
            in_data_i  = make_txn(walk);
            in_valid_i = 1'b1;
            finish_send();
            // Idle gap now and then
            if (chance(30)) begin
                @(posedge clk_i);
                #1;
            end
        end
        wait_drain();
        if (walk == 0 && req_cycles != reqs_before) begin
            $display("Memory request raised in test %0s with no walks", test_name);
            tb_errors++;
        end
        report_test(count, errs_before);
    endtask

    // Responses held back until the stage refuses input
    task automatic run_fill_test();
        int   errs_before;
        int   accepted;
        logic took;
        test_name   = "held_responses";
        gnt_pct     = 100;
        rsp_pct     = 0;
        rdy_pct     = 100;
        errs_before = err_count + tb_errors;
        accepted    = 0;
        in_data_i   = make_txn(100);
        in_valid_i  = 1'b1;
        for (int c = 0; c < FILL_CYCLES; c++) begin
            @(posedge clk_i);
            took = in_ready_o;
            #1;
            if (took && c >= FILL_CYCLES - 16) begin
                $display("Input accepted in test %0s while the queues were full", test_name);
                tb_errors++;
            end
            if (took) begin
                accepted++;
                in_data_i = make_txn(100);
            end
        end
        // Room rule allows DEPTH granted reads and no more
        if (accepted != int'(DEPTH)) begin
            $display("Fail %0s: expected %0d actual %0d", test_name, DEPTH, accepted);
            tb_errors++;
        end
        if (outstanding != int'(DEPTH)) begin
            $display("Fail %0s: expected %0d actual %0d", test_name, DEPTH, outstanding);
            tb_errors++;
        end
        rsp_pct = 60;
        finish_send();
        wait_drain();
        report_test(accepted + 1, errs_before);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        in_valid_i   = 1'b0;
        in_data_i    = '0;
        out_ready_i  = 1'b0;
        mem_gnt_i    = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i  = '0;
        gnt_pct      = 100;
        rsp_pct      = 100;
        rdy_pct      = 100;
        tb_errors    = 0;
        test_count   = 0;
        txn_total    = 0;
        next_id      = '0;
        test_name    = "reset";
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        run_random_test("skip_only", 20, 0, 50, 50, 100);
        run_random_test("walk_only", 20, 100, 100, 100, 100);
        run_random_test("mixed_random", 60, 50, 40, 40, 100);
        run_random_test("backpressure", 80, 50, 60, 60, 30);
        run_fill_test();
        $display("Summary: %0d tests, %0d transactions, %0d errors",
                 test_count, txn_total, err_count + tb_errors);
        if (err_count + tb_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/mrs_pkg.sv
design/mrs_fifo.sv
design/mrs_issue.sv
design/mrs_retire.sv
design/mem_read_stage.sv
bench/mrs_checker.sv
bench/tb_mem_read_stage.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and scan the log for the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_mem_read_stage -Mdir obj_dir -o tb_sim -f vlog.f

./obj_dir/tb_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
